//--- project.f
+incdir+hw
hw/hypot_data_pkg.sv
hw/hypot_ctrl_pkg.sv
hw/hypot_dp_if.sv
hw/hypot_ctrl.sv
hw/root_bit_counter.sv
hw/square_sum.sv
hw/root_finder.sv
hw/hypot_top.sv
testbench/tb_clock.sv
testbench/hypot_sva.sv
testbench/hypot_tb.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module hypot_tb -o hypot_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/hypot_sim +verilator+error+limit+100)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/hypot_tb.sv
`default_nettype none
`timescale 1ns/1ps

module hypot_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_CORNER     = 5;
    localparam int NUM_RANDOM     = 40;
    localparam int MAX_TXN_CYCLES = 22;    // Latency, up to 7 hold cycles, release
    localparam int TIMEOUT_CYCLES =
        (RESET_CYCLES + (NUM_CORNER + NUM_RANDOM + 10) * MAX_TXN_CYCLES) * 2;

    logic                     clk;
    logic                     rst_n;
    logic                     req;
    hypot_data_pkg::operand_t x;
    hypot_data_pkg::operand_t y;
    logic                     ack;
    hypot_data_pkg::root_t    mag;

    int seed       = 10;
    int pass_count = 0;
    int fail_count = 0;

    hypot_data_pkg::operand_t corner_x [NUM_CORNER] = '{8'd0, 8'd3, 8'd255, 8'd0, 8'd255};
    hypot_data_pkg::operand_t corner_y [NUM_CORNER] = '{8'd0, 8'd4, 8'd0, 8'd255, 8'd255};

    tb_clock #(.PERIOD_NS(8)) u_clock (.clk(clk));

    hypot_top u_hypot_top (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .x     (x),
        .y     (y),
        .ack   (ack),
        .mag   (mag)
    );

    // Largest r with r*r not above x*x + y*y
    function automatic hypot_data_pkg::root_t model_magnitude(
        input hypot_data_pkg::operand_t a,
        input hypot_data_pkg::operand_t b
    );
        int sum_sq;
        int r;
        sum_sq = int'(a) * int'(a) + int'(b) * int'(b);
        r = 0;
        while ((r + 1) * (r + 1) <= sum_sq) begin
            r++;
        end
        return hypot_data_pkg::root_t'(r);
    endfunction

    task automatic check_idle_outputs(input string phase, inout logic all_ok);
        logic ok;
        ok = (ack === 1'b0) && (mag === '0);
        assert (ok) else $display("CHECK FAILED at time %0t: %s ack=%b mag=%0d, expected zero",
                                  $time, phase, ack, mag);
        if (!ok) begin
            all_ok = 1'b0;
        end
    endtask

    task automatic check_result(
        input string                    name,
        input hypot_data_pkg::operand_t a,
        input hypot_data_pkg::operand_t b,
        input hypot_data_pkg::root_t    got
    );
        hypot_data_pkg::root_t expected;
        logic                  ok;
        expected = model_magnitude(a, b);
        ok = (got == expected);
        assert (ok) else $display("CHECK FAILED at time %0t: %s x=%0d y=%0d mag=%0d expected %0d",
                                  $time, name, a, b, got, expected);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("%s: x=%0d y=%0d mag=%0d expected=%0d %s",
                 name, a, b, got, expected, ok ? "passed" : "failed");
    endtask

    // One four-phase transaction, holding req for extra cycles after ack
    task automatic run_transaction(
        input  hypot_data_pkg::operand_t a,
        input  hypot_data_pkg::operand_t b,
        input  int                       hold_cycles,
        output hypot_data_pkg::root_t    got
    );
        while (ack) @(posedge clk);    // New req only with ack low
        x   <= a;
        y   <= b;
        req <= 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);
        got = mag;
        repeat (hold_cycles) @(posedge clk);    // Client back-pressure
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    initial begin
        hypot_data_pkg::operand_t a;
        hypot_data_pkg::operand_t b;
        hypot_data_pkg::root_t    got;
        int                       hold;
        int                       sva_fails;
        logic                     reset_ok;
        rst_n    = 1'b0;
        req      = 1'b0;
        x        = '0;
        y        = '0;
        reset_ok = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_idle_outputs("during reset", reset_ok);
        end
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_idle_outputs("after reset", reset_ok);
        if (reset_ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("reset state: %s", reset_ok ? "passed" : "failed");

        for (int i = 0; i < NUM_CORNER; i++) begin
            run_transaction(corner_x[i], corner_y[i], 0, got);
            check_result($sformatf("corner %0d", i), corner_x[i], corner_y[i], got);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            a    = hypot_data_pkg::operand_t'($random(seed));
            b    = hypot_data_pkg::operand_t'($random(seed));
            hold = int'({$random(seed)} % 32'd8);
            run_transaction(a, b, hold, got);
            check_result($sformatf("random %0d hold %0d", i, hold), a, b, got);
        end

        repeat (4) @(posedge clk);    // Let the last release assertions complete
        sva_fails = u_hypot_top.u_sva.fail_count;
        $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 pass_count, fail_count, sva_fails);
        if (fail_count == 0 && sva_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d cycles waiting for the DUT", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/hypot_sva.sv
`default_nettype none
`timescale 1ns/1ps

`include "hypot_consts.svh"

module hypot_sva (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        req,
    input wire                        ack,
    input wire hypot_data_pkg::root_t mag
);

    // Square, sum, one edge per root bit, then the ack register
    localparam int ACK_LATENCY = `HYP_ROOT_W + 3;

    int fail_count = 0;    // Read by the testbench at the end

    mag_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(mag))
    else begin
        fail_count++;
        $error("mag changed while ack was high");
    end

    ack_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) && !ack |-> ##ACK_LATENCY $rose(ack))
    else begin
        fail_count++;
        $error("ack did not rise at the expected edge after req");
    end

    ack_rise_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
    else begin
        fail_count++;
        $error("ack rose while req was low");
    end

    ack_fall_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
    else begin
        fail_count++;
        $error("ack fell while req was still high");
    end

    ack_release_a: assert property (@(posedge clk) disable iff (!rst_n)
        ack && !req |=> !ack)
    else begin
        fail_count++;
        $error("ack stayed high after req was released");
    end

endmodule

bind hypot_top hypot_sva u_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .mag   (mag)
);

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;    // Half period high, half low

endmodule

`default_nettype wire

//--- hw/hypot_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "hypot_consts.svh"

module hypot_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           req,
    input  wire hypot_data_pkg::operand_t x,
    input  wire hypot_data_pkg::operand_t y,
    output logic                          ack,
    output hypot_data_pkg::root_t         mag
);

    hypot_data_pkg::square_t  sum;
    hypot_data_pkg::bit_idx_t bit_idx;
    logic                     last;
    logic                     cnt_start;
    logic                     cnt_en;

    hypot_dp_if u_dp_if ();    // Step strobes

    hypot_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .last      (last),
        .cnt_start (cnt_start),
        .cnt_en    (cnt_en),
        .dp        (u_dp_if.ctrl)
    );

    root_bit_counter u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .cnt_start (cnt_start),
        .cnt_en    (cnt_en),
        .bit_idx   (bit_idx),
        .last      (last)
    );

    square_sum u_square_sum (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (x),
        .y     (y),
        .dp    (u_dp_if.dp),
        .sum   (sum)
    );

    root_finder u_root_finder (
        .clk     (clk),
        .rst_n   (rst_n),
        .sum     (sum),
        .bit_idx (bit_idx),
        .dp      (u_dp_if.dp),
        .root    (mag)       // Result straight from the root register
    );

endmodule

`default_nettype wire

//--- hw/root_finder.sv
`default_nettype none
`timescale 1ns/1ps

`include "hypot_consts.svh"

module root_finder (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire hypot_data_pkg::square_t  sum,
    input  wire hypot_data_pkg::bit_idx_t bit_idx,
    hypot_dp_if.dp                        dp,
    output hypot_data_pkg::root_t         root
);

    // Trial squared can reach 511*511, needs twice the root width
    localparam int TRIAL_SQ_W = 2 * `HYP_ROOT_W;

    hypot_data_pkg::root_t   trial_bit;
    hypot_data_pkg::root_t   trial;
    logic [TRIAL_SQ_W-1:0]   trial_sq;
    logic                    keep_bit;

    assign trial_bit = hypot_data_pkg::root_t'(1) << bit_idx;   // Bit under test
    assign trial     = root | trial_bit;
    assign trial_sq  = TRIAL_SQ_W'(trial) * TRIAL_SQ_W'(trial);

    // Keep the bit when the trial does not overshoot the sum
    assign keep_bit  = (trial_sq <= TRIAL_SQ_W'(sum));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            root <= '0;
        end else if (dp.root_clear) begin
            root <= '0;
        end else if (dp.root_step && keep_bit) begin
            root <= trial;
        end
    end

endmodule

`default_nettype wire

//--- hw/square_sum.sv
`default_nettype none
`timescale 1ns/1ps

`include "hypot_consts.svh"

module square_sum (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire hypot_data_pkg::operand_t x,
    input  wire hypot_data_pkg::operand_t y,
    hypot_dp_if.dp                   dp,
    output hypot_data_pkg::square_t  sum
);

    hypot_data_pkg::square_t sq_x;
    hypot_data_pkg::square_t sq_y;

    // Multiply stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_x <= '0;
            sq_y <= '0;
        end else if (dp.sq_load) begin
            sq_x <= hypot_data_pkg::square_t'(x * x);   // 16 bits fit in 17
            sq_y <= hypot_data_pkg::square_t'(y * y);
        end
    end

    // Add stage, held until the next request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (dp.sum_load) begin
            sum <= sq_x + sq_y;    // No carry out at 17 bits
        end
    end

endmodule

`default_nettype wire

//--- hw/root_bit_counter.sv
`default_nettype none
`timescale 1ns/1ps

`include "hypot_consts.svh"

module root_bit_counter (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cnt_start,
    input  wire                      cnt_en,
    output hypot_data_pkg::bit_idx_t bit_idx,
    output logic                     last
);

    // Top bit position of the root
    localparam hypot_data_pkg::bit_idx_t TOP_IDX =
        hypot_data_pkg::bit_idx_t'(`HYP_ROOT_W - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_idx <= '0;
        end else if (cnt_start) begin
            bit_idx <= TOP_IDX;
        end else if (cnt_en && !last) begin   // Stop at bit 0
            bit_idx <= bit_idx - 1'b1;
        end
    end

    assign last = (bit_idx == '0);

endmodule

`default_nettype wire

//--- hw/hypot_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "hypot_consts.svh"

module hypot_ctrl (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       req,
    output logic      ack,
    input  wire       last,
    output logic      cnt_start,
    output logic      cnt_en,
    hypot_dp_if.ctrl  dp
);

    hypot_ctrl_pkg::ctrl_state_t state;
    hypot_ctrl_pkg::ctrl_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            hypot_ctrl_pkg::ST_IDLE: begin
                if (req) begin            // ack is always low in idle
                    state_next = hypot_ctrl_pkg::ST_SQUARE;
                end
            end
            hypot_ctrl_pkg::ST_SQUARE: begin
                state_next = hypot_ctrl_pkg::ST_SUM;
            end
            hypot_ctrl_pkg::ST_SUM: begin
                state_next = hypot_ctrl_pkg::ST_ROOT;
            end
            hypot_ctrl_pkg::ST_ROOT: begin
                if (last) begin           // Bit 0 decided this cycle
                    state_next = hypot_ctrl_pkg::ST_HOLD;
                end
            end
            hypot_ctrl_pkg::ST_HOLD: begin
                if (!req) begin           // Drop ack once req is released
                    state_next = hypot_ctrl_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = hypot_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= hypot_ctrl_pkg::ST_IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            ack   <= (state_next == hypot_ctrl_pkg::ST_HOLD);   // High only in hold
        end
    end

    // Strobes decode the current state only
    assign dp.sq_load    = (state == hypot_ctrl_pkg::ST_SQUARE);
    assign dp.sum_load   = (state == hypot_ctrl_pkg::ST_SUM);
    assign dp.root_clear = (state == hypot_ctrl_pkg::ST_SUM);
    assign dp.root_step  = (state == hypot_ctrl_pkg::ST_ROOT);

    assign cnt_start = (state == hypot_ctrl_pkg::ST_SUM);   // Load top index
    assign cnt_en    = (state == hypot_ctrl_pkg::ST_ROOT);

endmodule

`default_nettype wire

//--- hw/hypot_dp_if.sv
`default_nettype none
`timescale 1ns/1ps

// Step strobes from the controller to the datapath blocks
interface hypot_dp_if;

    logic sq_load;       // Register both squares
    logic sum_load;      // Register the sum of squares
    logic root_clear;    // Zero the partial root
    logic root_step;     // Decide one root bit

    modport ctrl (
        output sq_load,
        output sum_load,
        output root_clear,
        output root_step
    );

    modport dp (
        input sq_load,
        input sum_load,
        input root_clear,
        input root_step
    );

endinterface

`default_nettype wire

//--- hw/hypot_ctrl_pkg.sv
`default_nettype none

package hypot_ctrl_pkg;

    // Controller sequence for one request
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,    // Waiting for req
        ST_SQUARE = 3'd1,    // Squares being loaded
        ST_SUM    = 3'd2,    // Sum loaded, root cleared
        ST_ROOT   = 3'd3,    // One root bit per cycle
        ST_HOLD   = 3'd4     // Result held, ack high
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/hypot_data_pkg.sv
`default_nettype none

`include "hypot_consts.svh"

package hypot_data_pkg;

    // Unsigned input operand
    typedef logic [`HYP_IN_W-1:0]   operand_t;

    // Single square or sum of both squares
    typedef logic [`HYP_SQ_W-1:0]   square_t;

    typedef logic [`HYP_ROOT_W-1:0] root_t;      // Magnitude result
    typedef logic [`HYP_IDX_W-1:0]  bit_idx_t;   // Root bit position

endpackage

`default_nettype wire

//--- hw/hypot_consts.svh
`ifndef HYPOT_CONSTS_SVH
`define HYPOT_CONSTS_SVH

// Operand width
`define HYP_IN_W   8
// Sum of squares, holds 255*255*2
`define HYP_SQ_W   17
// Root width, also the number of root steps
`define HYP_ROOT_W 9
`define HYP_IDX_W  4     // Enough for positions 8 down to 0

`endif
